// ==== Makefile ====
TOP := rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module rv_core -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  word_t      inst,
  input  word_t      dmem_rdata,
  output word_t      pc,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output byte_mask_t dmem_wmask,
  output logic       dmem_we,
  output logic       halted
);

  reg_addr_t rs1, rs2, rd;
  word_t     imm;
  funct3_t   funct3;
  logic      op_a_is_pc, reg_we, wb_sel_link, wb_sel_load;
  logic      is_load, is_store, jump, is_ebreak;
  word_t     rs1_data, rs2_data;
  word_t     op_a;
  word_t     sum;
  word_t     pc_plus4;
  word_t     wb_data;
  word_t     lsu_rdata;
  word_t     load_data;
  logic      store_ok;

  rv_decoder u_decoder (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .funct3(funct3),
    .op_a_is_pc(op_a_is_pc), .reg_we(reg_we), .wb_sel_link(wb_sel_link),
    .wb_sel_load(wb_sel_load), .is_load(is_load), .is_store(is_store),
    .jump(jump), .is_ebreak(is_ebreak)
  );

  rv_regfile u_regfile (
    .clk(clk), .arst_n(arst_n),
    .we(reg_we & ~halted), // no writeback once halted
    .waddr(rd), .raddr1(rs1), .raddr2(rs2), .wdata(wb_data),
    .rdata1(rs1_data), .rdata2(rs2_data)
  );

  // single adder for addresses, targets and addi/lui/auipc
  assign op_a      = op_a_is_pc ? pc : rs1_data; // lui gets x0 from decoder
  assign sum       = op_a + imm;
  assign pc_plus4  = pc + word_t'(4);
  assign dmem_addr = sum;

  rv_pc_unit u_pc_unit (
    .clk(clk), .arst_n(arst_n), .jump(jump), .is_ebreak(is_ebreak),
    .target(sum), .pc(pc), .halted(halted)
  );

  assign lsu_rdata = is_load ? dmem_rdata : '0; // memory data only for loads

  rv_lsu u_lsu (
    .funct3(funct3), .byte_off(sum[1:0]), .rs2_data(rs2_data),
    .dmem_rdata(lsu_rdata), .load_data(load_data), .store_data(dmem_wdata),
    .store_mask(dmem_wmask), .store_ok(store_ok)
  );

  assign dmem_we = is_store & store_ok & ~halted;

  assign wb_data = wb_sel_link ? pc_plus4 :
                   wb_sel_load ? load_data : sum;

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  word_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output funct3_t   funct3,
  output logic      op_a_is_pc,
  output logic      reg_we,
  output logic      wb_sel_link,
  output logic      wb_sel_load,
  output logic      is_load,
  output logic      is_store,
  output logic      jump,
  output logic      is_ebreak
);

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode = opcode_t'(inst[6:0]);
  assign funct3 = funct3_t'(inst[14:12]);
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  // lui reads x0 so operand a comes out as zero
  assign rs1 = (opcode == OP_LUI) ? '0 : inst[19:15];

  // immediates sign-extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm         = imm_i; // i-type unless overridden
    op_a_is_pc  = 1'b0;
    reg_we      = 1'b0;
    wb_sel_link = 1'b0;
    wb_sel_load = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    jump        = 1'b0;
    is_ebreak   = 1'b0;
    case (opcode)
      OP_IMM: begin
        reg_we = (funct3 == F3_B); // addi only
      end
      OP_LUI: begin
        imm    = imm_u;
        reg_we = 1'b1;
      end
      OP_AUIPC: begin
        imm        = imm_u;
        op_a_is_pc = 1'b1;
        reg_we     = 1'b1;
      end
      OP_JAL: begin
        imm         = imm_j;
        op_a_is_pc  = 1'b1;
        reg_we      = 1'b1;
        wb_sel_link = 1'b1;
        jump        = 1'b1;
      end
      OP_JALR: begin
        reg_we      = 1'b1;
        wb_sel_link = 1'b1;
        jump        = 1'b1;
      end
      OP_LOAD: begin
        reg_we      = 1'b1;
        wb_sel_load = 1'b1;
        is_load     = 1'b1;
      end
      OP_STORE: begin
        imm      = imm_s;
        is_store = 1'b1;
      end
      OP_SYSTEM: begin
        // ebreak has imm 1 and all other fields zero
        is_ebreak = (inst[31:7] == {12'h001, 13'h0000});
      end
      default: ; // unsupported opcode writes nothing
    endcase
  end

endmodule

// ==== hw/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  funct3_t    funct3,
  input  logic [1:0] byte_off,
  input  word_t      rs2_data,
  input  word_t      dmem_rdata,
  output word_t      load_data,
  output word_t      store_data,
  output byte_mask_t store_mask,
  output logic       store_ok
);

  word_t      rdata_shifted; // addressed lane moved to bit 0
  byte_mask_t base_mask;
  logic       half_aligned;
  logic       word_aligned;

  assign half_aligned  = ~byte_off[0];
  assign word_aligned  = (byte_off == 2'b00);
  assign rdata_shifted = dmem_rdata >> {byte_off, 3'b000};

  // load extraction and extension
  always_comb begin
    case (funct3)
      F3_B:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      F3_BU: load_data = {24'h00_0000, rdata_shifted[7:0]};
      F3_H:  load_data = half_aligned ? {{16{rdata_shifted[15]}}, rdata_shifted[15:0]} : '0;
      F3_HU: load_data = half_aligned ? {16'h0000, rdata_shifted[15:0]} : '0;
      F3_W:  load_data = word_aligned ? dmem_rdata : '0;
      default: load_data = '0; // unknown size
    endcase
  end

  // store lanes
  always_comb begin
    case (funct3)
      F3_B: begin
        base_mask = 4'b0001;
        store_ok  = 1'b1;
      end
      F3_H: begin
        base_mask = 4'b0011;
        store_ok  = half_aligned;
      end
      F3_W: begin
        base_mask = 4'b1111;
        store_ok  = word_aligned;
      end
      default: begin
        base_mask = 4'b0000;
        store_ok  = 1'b0;
      end
    endcase
  end

  assign store_data = rs2_data << {byte_off, 3'b000};
  assign store_mask = store_ok ? byte_mask_t'(base_mask << byte_off) : '0;

endmodule

// ==== hw/rv_pc_unit.sv ====
`timescale 1ns/1ps

module rv_pc_unit import rv_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  jump,
  input  logic  is_ebreak,
  input  word_t target,
  output word_t pc,
  output logic  halted
);

  run_state_e state;
  run_state_e state_next;
  word_t      pc_next;

  // jalr target gets bit 0 cleared
  assign pc_next = jump ? {target[XLEN-1:1], 1'b0} : pc + word_t'(4);

  always_comb begin
    state_next = state;
    case (state)
      RUN:     if (is_ebreak) state_next = HALTED;
      HALTED:  state_next = HALTED; // only reset leaves
      default: state_next = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc    <= RESET_PC;
      state <= RUN;
    end else begin
      state <= state_next;
      if (state == RUN) begin
        pc <= pc_next;
      end
    end
  end

  assign halted = (state == HALTED);

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  // data and address word
  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [XLEN/8-1:0] byte_mask_t; // one bit per byte lane
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // fetch address after reset
  localparam word_t RESET_PC = 32'h8000_0000;

  // base opcodes of the supported instructions
  localparam opcode_t OP_IMM    = 7'b001_0011;
  localparam opcode_t OP_LUI    = 7'b011_0111;
  localparam opcode_t OP_AUIPC  = 7'b001_0111;
  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_LOAD   = 7'b000_0011;
  localparam opcode_t OP_STORE  = 7'b010_0011;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // access size codes shared by loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // run/halt sequencer
  typedef enum logic {
    RUN,
    HALTED
  } run_state_e;

endpackage

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      we,
  input  reg_addr_t waddr,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  input  word_t     wdata,
  output word_t     rdata1,
  output word_t     rdata2
);

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== sources.f ====
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_pc_unit.sv
hw/rv_lsu.sv
hw/rv_core.sv
test/rv_core_props.sv
test/rv_core_tb.sv

// ==== test/rv_core_props.sv ====
`timescale 1ns/1ps

module rv_core_props import rv_pkg::*; (
  input logic       clk,
  input logic       arst_n,
  input word_t      pc,
  input byte_mask_t dmem_wmask,
  input logic       dmem_we,
  input logic       halted
);

  // no memory write once halted
  a_no_store_halted: assert property (
    @(posedge clk) disable iff (!arst_n) halted |-> !dmem_we
  ) else $error("dmem_we high while halted");

  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!arst_n) halted |=> $stable(pc)
  ) else $error("pc moved while halted");

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
  ) else $error("pc not word aligned");

  // a write always touches at least one lane
  a_mask_nonzero: assert property (
    @(posedge clk) disable iff (!arst_n) dmem_we |-> dmem_wmask != '0
  ) else $error("dmem_we high with empty mask");

endmodule

bind rv_core rv_core_props u_props (
  .clk(clk), .arst_n(arst_n), .pc(pc), .dmem_wmask(dmem_wmask),
  .dmem_we(dmem_we), .halted(halted)
);

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 4;
  localparam int TBL_MAX    = 64;
  localparam int MEM_WORDS  = 64;

  logic       clk;
  logic       arst_n;
  word_t      inst;
  word_t      dmem_rdata;
  word_t      pc;
  word_t      dmem_addr;
  word_t      dmem_wdata;
  byte_mask_t dmem_wmask;
  logic       dmem_we;
  logic       halted;

  word_t dmem [MEM_WORDS]; // memory seen by the DUT

  // reference model state
  word_t m_regs [32];
  word_t m_mem [MEM_WORDS];
  word_t m_pc;
  logic  m_halt;

  // stimulus table with expected values
  word_t      tbl_inst [TBL_MAX];
  word_t      tbl_pc [TBL_MAX];
  word_t      tbl_addr [TBL_MAX];
  word_t      tbl_wdata [TBL_MAX];
  byte_mask_t tbl_mask [TBL_MAX];
  logic       tbl_we [TBL_MAX];
  logic       tbl_halt [TBL_MAX];
  int         n_entries;

  int   seed;
  int   errors;
  int   n_bad;
  logic entry_bad;

  rv_core UUT (
    .clk(clk), .arst_n(arst_n), .inst(inst), .dmem_rdata(dmem_rdata),
    .pc(pc), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_wmask(dmem_wmask), .dmem_we(dmem_we), .halted(halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign dmem_rdata = dmem[dmem_addr[7:2]]; // combinational read

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wmask[b]) dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  function automatic word_t itype_inst(opcode_t op, funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                       logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t stype_inst(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
                                       logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t utype_inst(opcode_t op, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t jal_inst(reg_addr_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // run one instruction through the ISA model and record the expectation
  task automatic add_entry(input word_t ins);
    opcode_t    op;
    funct3_t    f3;
    reg_addr_t  rd;
    reg_addr_t  r1;
    reg_addr_t  r2;
    word_t      ii;
    word_t      is;
    word_t      sum;
    word_t      raw;
    word_t      w;
    word_t      wd;
    byte_mask_t mk;
    logic [1:0] off;
    logic       wr;
    logic       jmp;
    op  = ins[6:0];
    f3  = ins[14:12];
    rd  = ins[11:7];
    r1  = ins[19:15];
    r2  = ins[24:20];
    ii  = {{20{ins[31]}}, ins[31:20]};
    is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    sum = '0;
    w   = '0;
    wd  = '0;
    mk  = '0;
    wr  = 1'b0;
    jmp = 1'b0;
    case (op)
      OP_IMM: begin
        sum = m_regs[r1] + ii;
        w   = sum;
        wr  = (f3 == 3'b000);
      end
      OP_LUI: begin
        sum = {ins[31:12], 12'h000};
        w   = sum;
        wr  = 1'b1;
      end
      OP_AUIPC: begin
        sum = m_pc + {ins[31:12], 12'h000};
        w   = sum;
        wr  = 1'b1;
      end
      OP_JAL: begin
        sum = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        w   = m_pc + 32'd4;
        wr  = 1'b1;
        jmp = 1'b1;
      end
      OP_JALR: begin
        sum = m_regs[r1] + ii;
        w   = m_pc + 32'd4;
        wr  = 1'b1;
        jmp = 1'b1;
      end
      OP_LOAD: begin
        sum = m_regs[r1] + ii;
        off = sum[1:0];
        raw = m_mem[sum[7:2]] >> (8 * off);
        wr  = 1'b1;
        case (f3)
          F3_B:    w = {{24{raw[7]}}, raw[7:0]};
          F3_BU:   w = {24'h0, raw[7:0]};
          F3_H:    w = off[0] ? '0 : {{16{raw[15]}}, raw[15:0]};
          F3_HU:   w = off[0] ? '0 : {16'h0, raw[15:0]};
          F3_W:    w = (off == 2'b00) ? m_mem[sum[7:2]] : '0;
          default: w = '0;
        endcase
      end
      OP_STORE: begin
        sum = m_regs[r1] + is;
        off = sum[1:0];
        wd  = m_regs[r2] << (8 * off);
        if (f3 == F3_B) mk = 4'b0001 << off;
        else if (f3 == F3_H && !off[0]) mk = 4'b0011 << off;
        else if (f3 == F3_W && off == 2'b00) mk = 4'b1111;
      end
      default: ; // no effect besides pc+4
    endcase
    tbl_inst[n_entries]  = ins;
    tbl_addr[n_entries]  = sum;
    tbl_wdata[n_entries] = wd;
    tbl_mask[n_entries]  = mk;
    tbl_we[n_entries]    = (mk != '0) && !m_halt;
    if (!m_halt) begin
      for (int b = 0; b < 4; b++) begin
        if (mk[b]) m_mem[sum[7:2]][8*b +: 8] = wd[8*b +: 8];
      end
      if (wr && rd != '0) m_regs[rd] = w;
      m_pc = jmp ? {sum[31:1], 1'b0} : m_pc + 32'd4;
      if (op == OP_SYSTEM && ins[31:7] == 25'h000_2000) m_halt = 1'b1;
    end
    tbl_pc[n_entries]   = m_pc;
    tbl_halt[n_entries] = m_halt;
    n_entries++;
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      errors++;
      entry_bad = 1'b1;
    end
  endtask

  task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      errors++;
      entry_bad = 1'b1;
    end
  endtask

  // x1 points at word 16 of the memory
  task automatic build_table();
    add_entry(itype_inst(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h040));
    add_entry(utype_inst(OP_LUI, 5'd2, 20'h12345));
    add_entry(utype_inst(OP_AUIPC, 5'd3, 20'h00001));
    add_entry(itype_inst(OP_IMM, 3'b000, 5'd4, 5'd2, 12'hfff)); // -1
    add_entry(stype_inst(F3_W, 5'd1, 5'd2, 12'h000));
    add_entry(stype_inst(F3_W, 5'd1, 5'd3, 12'h004));
    add_entry(stype_inst(F3_W, 5'd1, 5'd4, 12'h008));
    add_entry(jal_inst(5'd5, 21'h000010));
    add_entry(utype_inst(OP_AUIPC, 5'd7, 20'h00000));
    add_entry(itype_inst(OP_JALR, 3'b000, 5'd6, 5'd7, 12'h009)); // odd target
    add_entry(stype_inst(F3_W, 5'd1, 5'd5, 12'h00c));
    add_entry(stype_inst(F3_W, 5'd1, 5'd6, 12'h000));
    for (int off = 0; off < 4; off++) begin
      add_entry(itype_inst(OP_LOAD, F3_B, 5'd8, 5'd1, 12'(32 + off)));
      add_entry(stype_inst(F3_W, 5'd1, 5'd8, 12'h000));
      add_entry(itype_inst(OP_LOAD, F3_BU, 5'd8, 5'd1, 12'(36 + off)));
      add_entry(stype_inst(F3_W, 5'd1, 5'd8, 12'h000));
    end
    for (int off = 0; off < 4; off += 2) begin
      add_entry(itype_inst(OP_LOAD, F3_H, 5'd9, 5'd1, 12'(32 + off)));
      add_entry(stype_inst(F3_W, 5'd1, 5'd9, 12'h000));
      add_entry(itype_inst(OP_LOAD, F3_HU, 5'd9, 5'd1, 12'(40 + off)));
      add_entry(stype_inst(F3_W, 5'd1, 5'd9, 12'h000));
    end
    add_entry(itype_inst(OP_LOAD, F3_W, 5'd10, 5'd1, 12'h02c));
    add_entry(stype_inst(F3_W, 5'd1, 5'd10, 12'h000));
    add_entry(itype_inst(OP_LOAD, F3_H, 5'd11, 5'd1, 12'h021)); // misaligned
    add_entry(stype_inst(F3_W, 5'd1, 5'd11, 12'h000));
    for (int off = 0; off < 4; off++) begin
      add_entry(stype_inst(F3_B, 5'd1, 5'd2, 12'(16 + off)));
    end
    add_entry(stype_inst(F3_H, 5'd1, 5'd4, 12'h010));
    add_entry(stype_inst(F3_H, 5'd1, 5'd4, 12'h012));
    add_entry(stype_inst(F3_W, 5'd1, 5'd2, 12'h011)); // misaligned so no write
    add_entry(32'h0010_0073); // ebreak
    add_entry(stype_inst(F3_W, 5'd1, 5'd2, 12'h000));
    add_entry(itype_inst(OP_IMM, 3'b000, 5'd12, 5'd0, 12'h001));
  endtask

  initial begin
    #1;
    #((n_entries + RST_CYCLES + 20) * CLK_PERIOD);
    $display("watchdog expired before the table finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    inst      = '0;
    seed      = 32'h4762;
    errors    = 0;
    n_bad     = 0;
    n_entries = 0;
    entry_bad = 1'b0;
    m_pc      = RESET_PC;
    m_halt    = 1'b0;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i]  = $random(seed) ^ {word_t'(i) << 24} ^ word_t'(i);
      m_mem[i] = dmem[i];
    end
    build_table();

    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_word("pc", RESET_PC, pc);
    check_word("halted", '0, word_t'(halted));

    for (int i = 0; i < n_entries; i++) begin
      entry_bad = 1'b0;
      inst = tbl_inst[i];
      #(CLK_PERIOD / 4); // combinational outputs settled
      check_word("dmem_we", word_t'(tbl_we[i]), word_t'(dmem_we));
      if (tbl_we[i]) begin
        check_word("dmem_addr", tbl_addr[i], dmem_addr);
        check_word("dmem_wdata", tbl_wdata[i], dmem_wdata);
        check_mask("dmem_wmask", tbl_mask[i], dmem_wmask);
      end
      @(negedge clk);
      check_word("pc", tbl_pc[i], pc);
      check_word("halted", word_t'(tbl_halt[i]), word_t'(halted));
      if (entry_bad) n_bad++;
      $display("entry %0d inst %h %s", i, tbl_inst[i], entry_bad ? "mismatch" : "ok");
    end

    $display("entries %0d, passed %0d, failed %0d, errors %0d",
             n_entries, n_entries - n_bad, n_bad, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
